//--- hw/coreTypes.sv
// core types: shared widths, op encodings, stage structs and trap causes.
package coreTypes;

    typedef logic [31:0] wordT;     // data or instruction word.
    typedef logic [4:0]  regAddrT;  // integer register index.
    typedef logic [11:0] csrAddrT;  // csr address.

    localparam csrAddrT csrMscratch = 12'h340;
    localparam csrAddrT csrMhartid  = 12'hF14;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluPassB
    } aluOpT;

    typedef enum logic [1:0] {
        csrNone,
        csrWrite,
        csrSet
    } csrOpT;

    // mcause encodings, only illegal instruction is raised here.
    typedef enum logic [3:0] {
        excInsnMisaligned   = 4'd0,
        excInsnAccessFault  = 4'd1,
        excIllegalInsn      = 4'd2,
        excBreakpoint       = 4'd3
    } exceptionCodeT;

    typedef struct packed {
        logic          valid;
        exceptionCodeT cause;
        wordT          value;  // faulting instruction word.
    } trapInfoT;

    typedef struct packed {
        aluOpT aluOp;
        csrOpT csrOp;           // csrNone also for read-only csr access.
        logic  useImm;
        logic  regWriteEnable;
        logic  csrReadEnable;
    } opInfoT;

    typedef struct packed {
        logic     valid;
        opInfoT   op;
        wordT     pc;
        wordT     insn;
        csrAddrT  csrAddr;
        regAddrT  srcRegAddr1;
        regAddrT  srcRegAddr2;
        regAddrT  dstRegAddr;
        wordT     imm;
        trapInfoT trapInfo;
    } decodeOutT;

    // decode fields plus the operands read in this stage.
    typedef struct packed {
        logic     valid;
        opInfoT   op;
        wordT     pc;
        wordT     insn;
        csrAddrT  csrAddr;
        regAddrT  srcRegAddr1;
        regAddrT  srcRegAddr2;
        regAddrT  dstRegAddr;
        wordT     imm;
        trapInfoT trapInfo;
        wordT     srcRegValue1;
        wordT     srcRegValue2;
        wordT     srcCsrValue;
    } regReadOutT;

    typedef struct packed {
        logic    valid;
        regAddrT dstRegAddr;
        wordT    value;
    } wbOutT;

endpackage

//--- hw/intRegFile.sv
// integer register file, 32 x 32 bits with two write-through read ports.
`timescale 1ns/1ps

module intRegFile import coreTypes::*; (
    input  logic    clk,
    input  logic    rstN,
    input  regAddrT readAddr1,
    input  regAddrT readAddr2,
    output wordT    readValue1,
    output wordT    readValue2,
    input  logic    writeEnable,
    input  regAddrT writeAddr,
    input  wordT    writeValue
);

    wordT regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeValue;  // x0 is never written.
        end
    end

    // a write in the same cycle is seen by the reader.
    always_comb begin
        if (readAddr1 == '0) begin
            readValue1 = '0;
        end else if (writeEnable && writeAddr == readAddr1) begin
            readValue1 = writeValue;
        end else begin
            readValue1 = regs[readAddr1];
        end

        if (readAddr2 == '0) begin
            readValue2 = '0;
        end else if (writeEnable && writeAddr == readAddr2) begin
            readValue2 = writeValue;
        end else begin
            readValue2 = regs[readAddr2];
        end
    end

endmodule

//--- hw/csrFile.sv
// csr file holding mscratch and a constant mhartid, with access checking.
`timescale 1ns/1ps

module csrFile import coreTypes::*; #(
    parameter wordT hartId = 32'h0
) (
    input  logic    clk,
    input  logic    rstN,
    input  csrAddrT readAddr,
    input  logic    readEnable,
    input  logic    writeIntent,
    output wordT    readValue,
    output logic    readIllegal,
    input  logic    writeEnable,
    input  csrAddrT writeAddr,
    input  wordT    writeValue
);

    wordT mscratch;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mscratch <= '0;
        end else if (writeEnable && writeAddr == csrMscratch) begin
            mscratch <= writeValue;
        end
    end

    always_comb begin
        readValue = '0;
        readIllegal = 1'b0;
        case (readAddr)
            csrMscratch: readValue = mscratch;
            csrMhartid: begin
                readValue = hartId;
                readIllegal = writeIntent;  // read-only.
            end
            default: readIllegal = readEnable;  // unknown address.
        endcase
    end

    // illegal writes are turned into traps before they reach this port.
    mhartidNeverWritten: assert property (
        @(posedge clk) disable iff (!rstN)
        writeEnable |-> writeAddr != csrMhartid
    );

endmodule

//--- hw/decodeStage.sv
// decode stage, registers one instruction and decodes it into a decoded op.
`timescale 1ns/1ps

module decodeStage import coreTypes::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      insnValid,
    input  wordT      insn,
    input  wordT      pc,
    input  logic      hold,
    input  logic      flush,
    output decodeOutT decodeOut
);

    localparam logic [6:0] opcodeOp    = 7'b0110011;
    localparam logic [6:0] opcodeOpImm = 7'b0010011;
    localparam logic [6:0] opcodeLui   = 7'b0110111;
    localparam logic [6:0] opcodeSystem = 7'b1110011;

    logic       validReg;
    wordT       insnReg;
    wordT       pcReg;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    regAddrT    rs1;
    opInfoT     op;
    wordT       imm;
    logic       illegal;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validReg <= 1'b0;
        end else if (flush) begin
            validReg <= 1'b0;
        end else if (!hold) begin
            validReg <= insnValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            insnReg <= insn;
            pcReg <= pc;
        end
    end

    assign opcode = insnReg[6:0];
    assign funct3 = insnReg[14:12];
    assign funct7 = insnReg[31:25];
    assign rs1 = insnReg[19:15];

    always_comb begin
        op = '0;
        op.aluOp = aluAdd;
        op.csrOp = csrNone;
        op.regWriteEnable = 1'b1;
        imm = '0;
        illegal = 1'b0;
        case (opcode)
            opcodeOp: begin
                if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    op.aluOp = aluSub;
                end else if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: op.aluOp = aluAdd;
                        3'b010: op.aluOp = aluSlt;
                        3'b100: op.aluOp = aluXor;
                        3'b110: op.aluOp = aluOr;
                        3'b111: op.aluOp = aluAnd;
                        default: illegal = 1'b1;
                    endcase
                end else begin
                    illegal = 1'b1;
                end
            end
            opcodeOpImm: begin
                op.useImm = 1'b1;
                imm = {{20{insnReg[31]}}, insnReg[31:20]};
                illegal = (funct3 != 3'b000);  // addi only.
            end
            opcodeLui: begin
                op.aluOp = aluPassB;
                op.useImm = 1'b1;
                imm = {insnReg[31:12], 12'b0};
            end
            opcodeSystem: begin
                op.csrReadEnable = 1'b1;
                case (funct3)
                    3'b001: op.csrOp = csrWrite;
                    3'b010: op.csrOp = (rs1 == '0) ? csrNone : csrSet;  // pure read.
                    default: illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            op = '0;  // trapping op touches no state.
        end
    end

    always_comb begin
        decodeOut.valid = validReg;
        decodeOut.op = op;
        decodeOut.pc = pcReg;
        decodeOut.insn = insnReg;
        decodeOut.csrAddr = insnReg[31:20];
        decodeOut.srcRegAddr1 = (opcode == opcodeLui) ? regAddrT'(0) : rs1;
        decodeOut.srcRegAddr2 = (opcode == opcodeOp) ? insnReg[24:20] : regAddrT'(0);
        decodeOut.dstRegAddr = insnReg[11:7];
        decodeOut.imm = imm;
        decodeOut.trapInfo.valid = validReg && illegal;
        decodeOut.trapInfo.cause = excIllegalInsn;
        decodeOut.trapInfo.value = insnReg;
    end

endmodule

//--- hw/regReadStage.sv
// register read stage, fetches integer and csr operands for the decoded op.
`timescale 1ns/1ps

module regReadStage import coreTypes::*; (
    input  logic       clk,
    input  logic       rstN,
    input  decodeOutT  decodeOut,
    input  logic       flush,
    output regReadOutT regReadOut,
    output regAddrT    readAddr1,
    output regAddrT    readAddr2,
    input  wordT       readValue1,
    input  wordT       readValue2,
    output csrAddrT    csrReadAddr,
    output logic       csrReadEnable,
    output logic       csrWriteIntent,
    input  wordT       csrReadValue,
    input  logic       csrReadIllegal
);

    // file reads are issued straight from the decode register.
    always_comb begin
        readAddr1 = decodeOut.srcRegAddr1;
        readAddr2 = decodeOut.srcRegAddr2;
        csrReadAddr = decodeOut.csrAddr;
        csrReadEnable = decodeOut.valid && decodeOut.op.csrReadEnable;
        csrWriteIntent = decodeOut.valid && decodeOut.op.csrOp != csrNone;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regReadOut <= '0;
        end else if (flush) begin
            regReadOut <= '0;  // bubble.
        end else begin
            regReadOut.valid <= decodeOut.valid;
            regReadOut.op <= decodeOut.op;
            regReadOut.pc <= decodeOut.pc;
            regReadOut.insn <= decodeOut.insn;
            regReadOut.csrAddr <= decodeOut.csrAddr;
            regReadOut.srcRegAddr1 <= decodeOut.srcRegAddr1;
            regReadOut.srcRegAddr2 <= decodeOut.srcRegAddr2;
            regReadOut.dstRegAddr <= decodeOut.dstRegAddr;
            regReadOut.imm <= decodeOut.imm;
            regReadOut.srcRegValue1 <= readValue1;
            regReadOut.srcRegValue2 <= readValue2;
            regReadOut.srcCsrValue <= csrReadValue;

            // a decode trap is older and keeps priority.
            if (!decodeOut.trapInfo.valid && csrReadIllegal) begin
                regReadOut.trapInfo.valid <= 1'b1;
                regReadOut.trapInfo.cause <= excIllegalInsn;
                regReadOut.trapInfo.value <= decodeOut.insn;
            end else begin
                regReadOut.trapInfo <= decodeOut.trapInfo;
            end
        end
    end

    flushLeavesBubble: assert property (
        @(posedge clk) disable iff (!rstN)
        flush |=> !regReadOut.valid
    );

endmodule

//--- hw/executeStage.sv
// execute stage, alu and csr update with registered writeback and trap report.
`timescale 1ns/1ps

module executeStage import coreTypes::*; (
    input  logic          clk,
    input  logic          rstN,
    input  regReadOutT    regReadOut,
    output wbOutT         wbOut,
    output logic          csrWriteEnable,
    output csrAddrT       csrWriteAddr,
    output wordT          csrWriteValue,
    output logic          trapValid,
    output exceptionCodeT trapCause,
    output wordT          trapValue,
    output wordT          trapPc
);

    wordT srcA;
    wordT operandB;
    wordT aluResult;
    wordT result;
    logic execValid;
    logic isTrap;

    assign srcA = regReadOut.srcRegValue1;
    assign operandB = regReadOut.op.useImm ? regReadOut.imm : regReadOut.srcRegValue2;

    always_comb begin
        case (regReadOut.op.aluOp)
            aluAdd:   aluResult = srcA + operandB;
            aluSub:   aluResult = srcA - operandB;
            aluAnd:   aluResult = srcA & operandB;
            aluOr:    aluResult = srcA | operandB;
            aluXor:   aluResult = srcA ^ operandB;
            aluSlt:   aluResult = ($signed(srcA) < $signed(operandB)) ? 32'd1 : 32'd0;
            aluPassB: aluResult = operandB;
            default:  aluResult = '0;
        endcase
    end

    // csr ops hand the old csr value to rd.
    assign result = regReadOut.op.csrReadEnable ? regReadOut.srcCsrValue : aluResult;

    // the op right behind a reported trap is squashed here.
    assign execValid = regReadOut.valid && !trapValid;
    assign isTrap = execValid && regReadOut.trapInfo.valid;

    always_comb begin
        csrWriteEnable = execValid && !regReadOut.trapInfo.valid &&
                         regReadOut.op.csrOp != csrNone;
        csrWriteAddr = regReadOut.csrAddr;
        if (regReadOut.op.csrOp == csrSet) begin
            csrWriteValue = srcA | regReadOut.srcCsrValue;
        end else begin
            csrWriteValue = srcA;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbOut <= '0;
            trapValid <= 1'b0;
            trapCause <= excIllegalInsn;
            trapValue <= '0;
            trapPc <= '0;
        end else begin
            wbOut.valid <= execValid && !regReadOut.trapInfo.valid &&
                           regReadOut.op.regWriteEnable;
            wbOut.dstRegAddr <= regReadOut.dstRegAddr;
            wbOut.value <= result;
            trapValid <= isTrap;
            trapCause <= regReadOut.trapInfo.cause;
            trapValue <= regReadOut.trapInfo.value;
            trapPc <= regReadOut.pc;
        end
    end

    wbAndTrapExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        !(wbOut.valid && trapValid)
    );

endmodule

//--- hw/pipelineController.sv
// pipeline controller, raw and csr hazard stalls plus flush after a trap.
`timescale 1ns/1ps

module pipelineController import coreTypes::*; (
    input  decodeOutT  decodeOut,
    input  regReadOutT regReadOut,
    input  logic       trapValid,
    output logic       decodeHold,
    output logic       decodeFlush,
    output logic       rrFlush,
    output logic       fetchStall
);

    logic pendingRegWrite;
    logic regHazard;
    logic csrHazard;

    // the op in execute writes back one edge too late for decode.
    assign pendingRegWrite = regReadOut.valid && regReadOut.op.regWriteEnable &&
                             regReadOut.dstRegAddr != '0;

    assign regHazard = decodeOut.valid && pendingRegWrite &&
                       (decodeOut.srcRegAddr1 == regReadOut.dstRegAddr ||
                        decodeOut.srcRegAddr2 == regReadOut.dstRegAddr);

    assign csrHazard = decodeOut.valid && decodeOut.op.csrReadEnable &&
                       regReadOut.valid && regReadOut.op.csrOp != csrNone &&
                       regReadOut.csrAddr == decodeOut.csrAddr;

    assign decodeHold = regHazard || csrHazard;
    assign decodeFlush = trapValid;
    assign rrFlush = trapValid || decodeHold;  // bubble on stall or trap.
    assign fetchStall = decodeHold || decodeFlush;

endmodule

//--- hw/coreSubsystem.sv
// core subsystem top, wires decode, register read, execute, files and control.
`timescale 1ns/1ps

module coreSubsystem import coreTypes::*; #(
    parameter wordT hartId = 32'h0
) (
    input  logic          clk,
    input  logic          rstN,
    input  logic          insnValid,
    input  wordT          insn,
    input  wordT          pc,
    output logic          fetchStall,
    output logic          wbValid,
    output regAddrT       wbAddr,
    output wordT          wbData,
    output logic          trapValid,
    output exceptionCodeT trapCause,
    output wordT          trapValue,
    output wordT          trapPc
);

    decodeOutT  decodeOut;
    regReadOutT regReadOut;
    wbOutT      wbOut;
    logic       decodeHold;
    logic       decodeFlush;
    logic       rrFlush;
    regAddrT    readAddr1;
    regAddrT    readAddr2;
    wordT       readValue1;
    wordT       readValue2;
    csrAddrT    csrReadAddr;
    logic       csrReadEnable;
    logic       csrWriteIntent;
    wordT       csrReadValue;
    logic       csrReadIllegal;
    logic       csrWriteEnable;
    csrAddrT    csrWriteAddr;
    wordT       csrWriteValue;

    assign wbValid = wbOut.valid;
    assign wbAddr = wbOut.dstRegAddr;
    assign wbData = wbOut.value;

    decodeStage decode (
        .clk(clk), .rstN(rstN),
        .insnValid(insnValid), .insn(insn), .pc(pc),
        .hold(decodeHold), .flush(decodeFlush),
        .decodeOut(decodeOut)
    );

    regReadStage regRead (
        .clk(clk), .rstN(rstN),
        .decodeOut(decodeOut), .flush(rrFlush), .regReadOut(regReadOut),
        .readAddr1(readAddr1), .readAddr2(readAddr2),
        .readValue1(readValue1), .readValue2(readValue2),
        .csrReadAddr(csrReadAddr), .csrReadEnable(csrReadEnable),
        .csrWriteIntent(csrWriteIntent), .csrReadValue(csrReadValue),
        .csrReadIllegal(csrReadIllegal)
    );

    executeStage execute (
        .clk(clk), .rstN(rstN),
        .regReadOut(regReadOut), .wbOut(wbOut),
        .csrWriteEnable(csrWriteEnable), .csrWriteAddr(csrWriteAddr),
        .csrWriteValue(csrWriteValue),
        .trapValid(trapValid), .trapCause(trapCause),
        .trapValue(trapValue), .trapPc(trapPc)
    );

    // writeback strobe doubles as the register file write port.
    intRegFile regFile (
        .clk(clk), .rstN(rstN),
        .readAddr1(readAddr1), .readAddr2(readAddr2),
        .readValue1(readValue1), .readValue2(readValue2),
        .writeEnable(wbOut.valid), .writeAddr(wbOut.dstRegAddr),
        .writeValue(wbOut.value)
    );

    csrFile #(.hartId(hartId)) csrs (
        .clk(clk), .rstN(rstN),
        .readAddr(csrReadAddr), .readEnable(csrReadEnable),
        .writeIntent(csrWriteIntent), .readValue(csrReadValue),
        .readIllegal(csrReadIllegal),
        .writeEnable(csrWriteEnable), .writeAddr(csrWriteAddr),
        .writeValue(csrWriteValue)
    );

    pipelineController control (
        .decodeOut(decodeOut), .regReadOut(regReadOut), .trapValid(trapValid),
        .decodeHold(decodeHold), .decodeFlush(decodeFlush),
        .rrFlush(rrFlush), .fetchStall(fetchStall)
    );

endmodule

//--- verification/coreSubsystemTb.sv
// testbench for the core subsystem, table-driven instruction stream with ordered strobe checks.
`timescale 1ns/1ps

module coreSubsystemTb import coreTypes::*; ();

    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opSystem = 7'b1110011;
    localparam logic [6:0] opLoad   = 7'b0000011;  // not supported by the core.

    localparam logic [1:0] kindNone = 2'd0;
    localparam logic [1:0] kindWb   = 2'd1;
    localparam logic [1:0] kindTrap = 2'd2;

    localparam wordT pcBase     = 32'h0000_1000;
    localparam int   stallLimit = 20;
    localparam int   drainLimit = 100;

    // one retired strobe, tag is rd for a writeback and the cause for a trap.
    typedef struct packed {
        logic [1:0]  kind;
        logic [4:0]  tag;
        logic [31:0] value;
        logic [31:0] pc;
    } outcomeT;

    logic          clk;
    logic          rstN;
    logic          insnValid;
    wordT          insn;
    wordT          pc;
    logic          fetchStall;
    logic          wbValid;
    regAddrT       wbAddr;
    wordT          wbData;
    logic          trapValid;
    exceptionCodeT trapCause;
    wordT          trapValue;
    wordT          trapPc;

    wordT    rowInsn [$];
    logic    rowBackToBack [$];
    outcomeT rowExpect [$];
    outcomeT gotQ [$];
    outcomeT wantQ [$];
    logic    stallSeen;
    logic [31:0] rngState;

    coreSubsystem #(.hartId(32'h0000_0007)) dut (
        .clk(clk), .rstN(rstN),
        .insnValid(insnValid), .insn(insn), .pc(pc),
        .fetchStall(fetchStall),
        .wbValid(wbValid), .wbAddr(wbAddr), .wbData(wbData),
        .trapValid(trapValid), .trapCause(trapCause),
        .trapValue(trapValue), .trapPc(trapPc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic wordT encodeR(input logic [6:0] funct7, input int rs2, input int rs1,
                                     input logic [2:0] funct3, input int rd);
        return {funct7, 5'(rs2), 5'(rs1), funct3, 5'(rd), opOp};
    endfunction

    function automatic wordT encodeI(input logic [11:0] imm, input int rs1,
                                     input logic [2:0] funct3, input int rd,
                                     input logic [6:0] opcode);
        return {imm, 5'(rs1), funct3, 5'(rd), opcode};
    endfunction

    function automatic wordT encodeU(input logic [19:0] imm, input int rd);
        return {imm, 5'(rd), opLui};
    endfunction

    function automatic outcomeT makeOutcome(input logic [1:0] kind, input logic [4:0] tag,
                                            input wordT value, input wordT atPc);
        outcomeT o;
        o.kind = kind;
        o.tag = tag;
        o.value = value;
        o.pc = atPc;
        return o;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkEqual(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            failRun($sformatf("CHECK FAILED at %0d ns: %s is 0x%08h, expected 0x%08h",
                              $time, name, actual, expected));
        end
    endtask

    // trap rows carry their own pc so trapPc can be checked.
    task automatic addRow(input wordT word, input logic backToBack, input logic [1:0] kind,
                          input logic [4:0] tag, input wordT value);
        wordT rowPc;
        rowPc = pcBase + 32'(rowInsn.size()) * 32'd4;
        rowInsn.push_back(word);
        rowBackToBack.push_back(backToBack);
        rowExpect.push_back(makeOutcome(kind, tag, value, (kind == kindTrap) ? rowPc : '0));
    endtask

    task automatic buildTable();
        wordT w;
        addRow(encodeU(20'h12345, 1), 1'b0, kindWb, 5'd1, 32'h1234_5000);        // lui x1.
        addRow(encodeI(12'h678, 1, 3'b000, 1, opImm), 1'b1, kindWb, 5'd1, 32'h1234_5678);
        addRow(encodeI(12'hFFB, 0, 3'b000, 2, opImm), 1'b0, kindWb, 5'd2, 32'hFFFF_FFFB);
        addRow(encodeR(7'h00, 2, 1, 3'b000, 3), 1'b1, kindWb, 5'd3, 32'h1234_5673); // add.
        addRow(encodeR(7'h20, 3, 1, 3'b000, 4), 1'b1, kindWb, 5'd4, 32'h0000_0005); // sub.
        addRow(encodeR(7'h00, 3, 1, 3'b111, 5), 1'b0, kindWb, 5'd5, 32'h1234_5670); // and.
        addRow(encodeR(7'h00, 2, 4, 3'b110, 6), 1'b0, kindWb, 5'd6, 32'hFFFF_FFFF); // or.
        addRow(encodeR(7'h00, 6, 1, 3'b100, 7), 1'b0, kindWb, 5'd7, 32'hEDCB_A987); // xor.
        addRow(encodeR(7'h00, 4, 2, 3'b010, 8), 1'b0, kindWb, 5'd8, 32'h0000_0001); // slt.
        addRow(encodeR(7'h00, 2, 4, 3'b010, 9), 1'b0, kindWb, 5'd9, 32'h0000_0000);
        addRow(encodeI(12'h055, 0, 3'b000, 0, opImm), 1'b0, kindWb, 5'd0, 32'h0000_0055);
        addRow(encodeR(7'h00, 4, 0, 3'b000, 10), 1'b1, kindWb, 5'd10, 32'h0000_0005);

        // mscratch starts at zero, mhartid is the dut parameter.
        addRow(encodeI(12'h340, 1, 3'b001, 11, opSystem), 1'b0, kindWb, 5'd11, 32'h0);
        addRow(encodeI(12'h340, 0, 3'b010, 12, opSystem), 1'b1, kindWb, 5'd12, 32'h1234_5678);
        addRow(encodeI(12'hF14, 0, 3'b010, 13, opSystem), 1'b0, kindWb, 5'd13, 32'h0000_0007);
        addRow(encodeI(12'h340, 4, 3'b010, 14, opSystem), 1'b0, kindWb, 5'd14, 32'h1234_5678);
        addRow(encodeI(12'h340, 0, 3'b010, 15, opSystem), 1'b0, kindWb, 5'd15, 32'h1234_567D);

        // each trap is followed by two independent ops that get flushed.
        w = encodeI(12'h000, 2, 3'b010, 1, opLoad);
        addRow(w, 1'b0, kindTrap, 5'd2, w);
        addRow(encodeI(12'h111, 0, 3'b000, 20, opImm), 1'b1, kindNone, 5'd0, 32'h0);
        addRow(encodeI(12'h222, 0, 3'b000, 21, opImm), 1'b1, kindNone, 5'd0, 32'h0);
        addRow(encodeI(12'h333, 0, 3'b000, 22, opImm), 1'b0, kindWb, 5'd22, 32'h0000_0333);
        addRow(encodeR(7'h00, 22, 20, 3'b000, 23), 1'b1, kindWb, 5'd23, 32'h0000_0333);

        w = encodeI(12'hF14, 1, 3'b001, 24, opSystem);  // csrrw to mhartid.
        addRow(w, 1'b0, kindTrap, 5'd2, w);
        addRow(encodeI(12'h444, 0, 3'b000, 25, opImm), 1'b1, kindNone, 5'd0, 32'h0);
        addRow(encodeI(12'h555, 0, 3'b000, 26, opImm), 1'b1, kindNone, 5'd0, 32'h0);

        w = encodeI(12'h7C0, 0, 3'b010, 27, opSystem);  // unknown csr.
        addRow(w, 1'b0, kindTrap, 5'd2, w);
        addRow(encodeI(12'h666, 0, 3'b000, 28, opImm), 1'b1, kindNone, 5'd0, 32'h0);
        addRow(encodeI(12'h777, 0, 3'b000, 29, opImm), 1'b1, kindNone, 5'd0, 32'h0);

        // flushed and trapping ops left their registers at zero.
        addRow(encodeR(7'h00, 28, 25, 3'b000, 30), 1'b0, kindWb, 5'd30, 32'h0);
        addRow(encodeR(7'h00, 13, 24, 3'b000, 31), 1'b0, kindWb, 5'd31, 32'h0000_0007);
        addRow(encodeR(7'h00, 31, 30, 3'b010, 9), 1'b1, kindWb, 5'd9, 32'h0000_0001);
    endtask

    // strobes are stable around the falling edge.
    always @(negedge clk) begin
        if (rstN) begin
            if (wbValid) begin
                gotQ.push_back(makeOutcome(kindWb, wbAddr, wbData, '0));
            end
            if (trapValid) begin
                gotQ.push_back(makeOutcome(kindTrap, 5'(trapCause), trapValue, trapPc));
            end
            if (fetchStall && !trapValid) begin
                stallSeen = 1'b1;  // hazard stall, not a trap flush.
            end
        end
    end

    initial begin
        int gap;
        int waited;
        outcomeT got;
        outcomeT want;

        rstN = 1'b0;
        insnValid = 1'b0;
        insn = '0;
        pc = '0;
        stallSeen = 1'b0;
        rngState = 32'h101c_0643;

        buildTable();
        foreach (rowExpect[i]) begin
            if (rowExpect[i].kind != kindNone) begin
                wantQ.push_back(rowExpect[i]);
            end
        end

        repeat (3) @(posedge clk);
        #2;
        rstN = 1'b1;

        // quiet outputs until the first instruction.
        repeat (3) begin
            checkEqual("wbValid", 32'(wbValid), 32'd0);
            checkEqual("trapValid", 32'(trapValid), 32'd0);
            checkEqual("fetchStall", 32'(fetchStall), 32'd0);
            @(posedge clk);
            #2;
        end

        for (int i = 0; i < rowInsn.size(); i++) begin
            rngState = xorshift32(rngState);
            gap = rowBackToBack[i] ? 0 : int'(rngState % 32'd3);
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            insnValid = 1'b1;
            insn = rowInsn[i];
            pc = pcBase + 32'(i) * 32'd4;
            waited = 0;
            while (fetchStall) begin
                @(posedge clk);
                #2;
                waited++;
                if (waited > stallLimit) begin
                    failRun($sformatf("fetchStall stayed high, row %0d never accepted", i));
                end
            end
            @(posedge clk);  // taken on this edge.
            #2;
            insnValid = 1'b0;
        end

        waited = 0;
        while (gotQ.size() < wantQ.size()) begin
            @(posedge clk);
            waited++;
            if (waited > drainLimit) begin
                failRun("timed out waiting for the remaining writeback and trap strobes");
            end
        end
        repeat (4) @(posedge clk);  // room for a stray extra strobe.

        checkEqual("strobe count", 32'(gotQ.size()), 32'(wantQ.size()));
        for (int i = 0; i < wantQ.size(); i++) begin
            got = gotQ[i];
            want = wantQ[i];
            checkEqual($sformatf("strobe kind [%0d]", i), 32'(got.kind), 32'(want.kind));
            if (want.kind == kindWb) begin
                checkEqual($sformatf("wbAddr [%0d]", i), 32'(got.tag), 32'(want.tag));
                checkEqual($sformatf("wbData [%0d]", i), got.value, want.value);
            end else begin
                checkEqual($sformatf("trapCause [%0d]", i), 32'(got.tag), 32'(want.tag));
                checkEqual($sformatf("trapValue [%0d]", i), got.value, want.value);
                checkEqual($sformatf("trapPc [%0d]", i), got.pc, want.pc);
            end
        end
        checkEqual("fetchStall raised", 32'(stallSeen), 32'd1);

        $display("Verification passed");
        $finish;
    end

endmodule

//--- compile.f
hw/coreTypes.sv
hw/intRegFile.sv
hw/csrFile.sv
hw/decodeStage.sv
hw/regReadStage.sv
hw/executeStage.sv
hw/pipelineController.sv
hw/coreSubsystem.sv
verification/coreSubsystemTb.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it, and look for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module coreSubsystemTb \
    -f compile.f -o simv || { echo "build failed"; exit 1; }
output=$(./obj_dir/simv 2>&1)
echo "$output"
echo "$output" | grep -qx "Verification passed" && exit 0 || exit 1
